/* Makefile */
# Verilator simulation of the AXI4 write DMA

VERILATOR ?= verilator
TOP       ?= tb_dma_wr
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST OK" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/axi_pkg.sv */
// AXI4 write channel types
`include "dma_config.svh"

package axi_pkg;

    localparam int strb_w = `DMA_DATA_W / 8;
    localparam int axi_burst_size = $clog2(strb_w);

    // AW channel beat, INCR bursts of full-width transfers
    typedef struct packed {
        logic [`DMA_ADDR_W-1:0] addr;
        logic [7:0]             len;
    } axi_aw_t;

    // W channel beat
    typedef struct packed {
        logic [`DMA_DATA_W-1:0] data;
        logic [strb_w-1:0]      strb;
        logic                   last;
    } axi_w_t;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } axi_resp_t;

endpackage

/* common/dma_config.svh */
// DMA write engine configuration
`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// datapath and descriptor widths
`define DMA_DATA_W 32
`define DMA_ADDR_W 32
`define DMA_LEN_W 20
`define DMA_TAG_W 8

// beats per AXI burst
`define DMA_MAX_BURST_LEN 16

// 2**aw entries, also the limit on outstanding bursts
`define DMA_STATUS_FIFO_AW 5

`define DMA_BEAT_FIFO_AW 5

`endif

/* common/dma_pkg.sv */
// DMA descriptor and status types
`include "dma_config.svh"

package dma_pkg;

    typedef enum logic [3:0] {
        err_none          = 4'd0,
        err_axi_wr_slverr = 4'd6,
        err_axi_wr_decerr = 4'd7
    } dma_err_t;

    typedef struct packed {
        logic [`DMA_ADDR_W-1:0] addr;
        logic [`DMA_LEN_W-1:0]  len;
        logic [`DMA_TAG_W-1:0]  tag;
    } dma_desc_t;

    // one status per descriptor, len counts bytes written
    typedef struct packed {
        logic [`DMA_LEN_W-1:0] len;
        logic [`DMA_TAG_W-1:0] tag;
        dma_err_t              error;
    } dma_sts_t;

    // one record per burst, last marks the final burst of a descriptor
    typedef struct packed {
        logic [`DMA_LEN_W-1:0] len;
        logic [`DMA_TAG_W-1:0] tag;
        logic                  last;
    } dma_burst_rec_t;

endpackage

/* dma_wr/dma_wr_ctrl.sv */
// DMA write transfer control
`include "dma_config.svh"

module dma_wr_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    enable,
    input  dma_pkg::dma_desc_t      desc,
    input  logic                    desc_valid,
    output logic                    desc_ready,
    input  logic [`DMA_DATA_W-1:0]  s_data,
    input  logic                    s_last,
    input  logic                    s_valid,
    output logic                    s_ready,
    output axi_pkg::axi_aw_t        aw,
    output logic                    aw_valid,
    input  logic                    aw_ready,
    output axi_pkg::axi_w_t         beat,
    output logic                    beat_valid,
    input  logic                    beat_room,
    output dma_pkg::dma_burst_rec_t rec,
    output logic                    rec_push,
    output logic                    burst_issue,
    input  logic                    slot_free
);

    localparam int addr_w = `DMA_ADDR_W;
    localparam int len_w = `DMA_LEN_W;
    localparam int max_burst_bytes = `DMA_MAX_BURST_LEN * axi_pkg::strb_w;

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_write,
        st_finish_burst,
        st_drop_data
    } state_t;

    state_t                state;
    state_t                state_next;
    logic [addr_w-1:0]     addr_reg;
    logic [addr_w-1:0]     addr_next;
    logic [len_w-1:0]      op_count_reg;
    logic [len_w-1:0]      op_count_next;
    logic [len_w-1:0]      length_reg;
    logic [len_w-1:0]      length_next;
    logic [`DMA_TAG_W-1:0] tag_reg;
    logic [`DMA_TAG_W-1:0] tag_next;
    logic [7:0]            beat_count_reg;
    logic [7:0]            beat_count_next;
    logic                  last_transfer_reg;
    logic                  last_transfer_next;
    logic                  first_burst_reg;
    logic                  first_burst_next;
    logic                  desc_ready_next;
    logic                  s_ready_next;
    logic                  aw_valid_next;
    axi_pkg::axi_aw_t      aw_next;
    logic [12:0]           boundary;
    logic [12:0]           tr_bytes;
    logic [7:0]            awlen;

    assign burst_issue = aw_valid && aw_ready;

    // burst size is the smallest of remaining length, max burst and 4 KiB distance
    always_comb begin
        boundary = 13'h1000 - {1'b0, addr_reg[11:0]};
        if (op_count_reg < len_w'(max_burst_bytes)) begin
            tr_bytes = op_count_reg[12:0];
        end else begin
            tr_bytes = 13'(max_burst_bytes);
        end
        if (tr_bytes > boundary) begin
            tr_bytes = boundary;
        end
        awlen = 8'((tr_bytes - 13'd1) >> axi_pkg::axi_burst_size);
    end

    always_comb begin
        state_next = state;
        addr_next = addr_reg;
        op_count_next = op_count_reg;
        length_next = length_reg;
        tag_next = tag_reg;
        beat_count_next = beat_count_reg;
        last_transfer_next = last_transfer_reg;
        first_burst_next = first_burst_reg;
        desc_ready_next = 1'b0;
        s_ready_next = 1'b0;
        aw_next = aw;
        aw_valid_next = aw_valid && !aw_ready;
        beat = '{data: s_data, strb: '1, last: beat_count_reg == 8'd0};
        beat_valid = 1'b0;
        rec = '{len: length_reg + len_w'(axi_pkg::strb_w), tag: tag_reg, last: 1'b1};
        rec_push = 1'b0;

        case (state)
            st_idle: begin
                desc_ready_next = enable && slot_free;
                // word aligned only, low address and length bits dropped
                addr_next = desc.addr & ~addr_w'(axi_pkg::strb_w - 1);
                op_count_next = desc.len & ~len_w'(axi_pkg::strb_w - 1);
                tag_next = desc.tag;
                length_next = '0;
                first_burst_next = 1'b1;
                if (desc_valid && desc_ready) begin
                    desc_ready_next = 1'b0;
                    state_next = st_start;
                end
            end
            st_start: begin
                // the first AW waits for stream data
                if (!aw_valid && slot_free && (s_valid || !first_burst_reg)) begin
                    aw_next = '{addr: addr_reg, len: awlen};
                    aw_valid_next = 1'b1;
                    addr_next = addr_reg + addr_w'(tr_bytes);
                    op_count_next = op_count_reg - len_w'(tr_bytes);
                    last_transfer_next = len_w'(tr_bytes) == op_count_reg;
                    beat_count_next = awlen;
                    first_burst_next = 1'b0;
                    s_ready_next = beat_room;
                    state_next = st_write;
                end
            end
            st_write: begin
                s_ready_next = beat_room;
                if (s_ready && s_valid) begin
                    beat_valid = 1'b1;
                    length_next = length_reg + len_w'(axi_pkg::strb_w);
                    beat_count_next = beat_count_reg - 8'd1;
                    if (s_last || beat_count_reg == 8'd0) begin
                        rec_push = 1'b1;
                        s_ready_next = 1'b0;
                    end
                    if (s_last) begin
                        // frame ended, pad out whatever is left of the burst
                        state_next = (beat_count_reg == 8'd0) ? st_idle : st_finish_burst;
                    end else if (beat_count_reg == 8'd0) begin
                        if (last_transfer_reg) begin
                            s_ready_next = 1'b1;
                            state_next = st_drop_data;
                        end else begin
                            rec.last = 1'b0;
                            state_next = st_start;
                        end
                    end
                end
            end
            st_finish_burst: begin
                if (beat_room) begin
                    beat = '{data: '0, strb: '0, last: beat_count_reg == 8'd0};
                    beat_valid = 1'b1;
                    beat_count_next = beat_count_reg - 8'd1;
                    if (beat_count_reg == 8'd0) begin
                        state_next = st_idle;
                    end
                end
            end
            st_drop_data: begin
                // length used up, discard the rest of the frame
                s_ready_next = 1'b1;
                if (s_ready && s_valid && s_last) begin
                    s_ready_next = 1'b0;
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            desc_ready <= 1'b0;
            s_ready <= 1'b0;
            aw_valid <= 1'b0;
        end else begin
            state <= state_next;
            desc_ready <= desc_ready_next;
            s_ready <= s_ready_next;
            aw_valid <= aw_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        aw <= aw_next;
        addr_reg <= addr_next;
        op_count_reg <= op_count_next;
        length_reg <= length_next;
        tag_reg <= tag_next;
        beat_count_reg <= beat_count_next;
        last_transfer_reg <= last_transfer_next;
        first_burst_reg <= first_burst_next;
    end

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw));

endmodule

/* dma_wr/dma_wr_status.sv */
// DMA write completion and status
`include "dma_config.svh"

module dma_wr_status (
    input  logic                    clk,
    input  logic                    rst,
    input  dma_pkg::dma_burst_rec_t rec,
    input  logic                    rec_push,
    input  logic                    burst_issue,
    input  axi_pkg::axi_resp_t      b_resp,
    input  logic                    b_valid,
    output logic                    b_ready,
    output dma_pkg::dma_sts_t       sts,
    output logic                    sts_valid,
    output logic                    slot_free
);

    localparam int fifo_aw = `DMA_STATUS_FIFO_AW;

    dma_pkg::dma_burst_rec_t rec_mem [2**fifo_aw];
    dma_pkg::dma_burst_rec_t head;
    logic [fifo_aw:0]        wr_ptr;
    logic [fifo_aw:0]        rd_ptr;
    logic [fifo_aw:0]        active_count;
    logic                    fifo_empty;
    logic                    b_hs;
    axi_pkg::axi_resp_t      resp_reg;
    axi_pkg::axi_resp_t      resp_next;
    dma_pkg::dma_err_t       err;

    assign fifo_empty = wr_ptr == rd_ptr;
    assign b_hs = b_valid && b_ready;
    assign head = rec_mem[rd_ptr[fifo_aw-1:0]];
    assign slot_free = active_count != (fifo_aw + 1)'(2**fifo_aw);

    // error response sticks until the descriptor's last burst completes
    always_comb begin
        resp_next = resp_reg;
        if (b_hs && (b_resp == axi_pkg::resp_slverr || b_resp == axi_pkg::resp_decerr)) begin
            resp_next = b_resp;
        end
        case (resp_next)
            axi_pkg::resp_slverr: err = dma_pkg::err_axi_wr_slverr;
            axi_pkg::resp_decerr: err = dma_pkg::err_axi_wr_decerr;
            default: err = dma_pkg::err_none;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rec_push) begin
            rec_mem[wr_ptr[fifo_aw-1:0]] <= rec;
        end
        if (b_hs) begin
            sts <= '{len: head.len, tag: head.tag, error: err};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            active_count <= '0;
            resp_reg <= axi_pkg::resp_okay;
            b_ready <= 1'b0;
            sts_valid <= 1'b0;
        end else begin
            b_ready <= !fifo_empty && !b_hs;
            sts_valid <= b_hs && head.last;
            resp_reg <= resp_next;
            if (rec_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (b_hs) begin
                rd_ptr <= rd_ptr + 1'b1;
                if (head.last) begin
                    resp_reg <= axi_pkg::resp_okay;
                end
            end
            if (burst_issue && !b_hs) begin
                active_count <= active_count + 1'b1;
            end else if (!burst_issue && b_hs) begin
                active_count <= active_count - 1'b1;
            end
        end
    end

    b_with_record: assert property (@(posedge clk) disable iff (rst)
        b_hs |-> !fifo_empty);

endmodule

/* dv/dma_wr_checker.sv */
// DMA write traffic checker
`include "dma_config.svh"

module dma_wr_checker #(
    parameter int ROWS = 1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   enable,
    input  logic                   desc_ready,
    input  axi_pkg::axi_aw_t       aw,
    input  logic                   aw_valid,
    input  logic                   aw_ready,
    input  axi_pkg::axi_w_t        w,
    input  logic                   w_valid,
    input  logic                   w_ready,
    input  dma_pkg::dma_sts_t      sts,
    input  logic                   sts_valid,
    input  logic [`DMA_ADDR_W-1:0] tbl_addr [ROWS],
    input  logic [`DMA_LEN_W-1:0]  tbl_len [ROWS],
    input  logic [`DMA_TAG_W-1:0]  tbl_tag [ROWS],
    input  int                     tbl_words [ROWS],
    input  logic [3:0]             tbl_err [ROWS],
    output int                     errors,
    output int                     checks,
    output int                     sts_seen,
    output int                     pending
);

    localparam int addr_w = `DMA_ADDR_W;
    localparam int data_w = `DMA_DATA_W;
    localparam int len_w = `DMA_LEN_W;
    localparam int word_bytes = `DMA_DATA_W / 8;
    localparam int burst_bytes = `DMA_MAX_BURST_LEN * word_bytes;

    axi_pkg::axi_aw_t    exp_aw [$];
    axi_pkg::axi_w_t     exp_w [$];
    dma_pkg::dma_sts_t   exp_sts [$];
    logic [data_w-1:0]   next_word;
    logic                enable_q = 1'b0;
    logic                built = 1'b0;

    // expected traffic of one row, word is the stream counter at the row's first word
    task automatic expect_row(input int r, inout logic [data_w-1:0] word);
        axi_pkg::axi_aw_t  a;
        axi_pkg::axi_w_t   beat;
        dma_pkg::dma_sts_t st;
        int                rem;
        int                left;
        int                tr;
        int                beats;
        int                written;
        a.addr = tbl_addr[r] & ~addr_w'(word_bytes - 1);
        rem = int'(tbl_len[r]) / word_bytes * word_bytes;
        left = tbl_words[r];
        written = 0;
        while (rem > 0 && left > 0) begin
            // a burst stops at the burst limit and at each 4 KiB boundary
            tr = (rem < burst_bytes) ? rem : burst_bytes;
            if (tr > 4096 - int'(a.addr[11:0])) begin
                tr = 4096 - int'(a.addr[11:0]);
            end
            beats = tr / word_bytes;
            a.len = 8'(beats - 1);
            exp_aw.push_back(a);
            for (int b = 0; b < beats; b++) begin
                beat.last = (b == beats - 1);
                if (b < left) begin
                    beat.data = word + data_w'(written);
                    beat.strb = '1;
                    written++;
                end else begin
                    // frame ended early, the rest of the burst is padding
                    beat.data = '0;
                    beat.strb = '0;
                end
                exp_w.push_back(beat);
            end
            left = (left > beats) ? left - beats : 0;
            a.addr = a.addr + addr_w'(tr);
            rem = rem - tr;
        end
        st.len = len_w'(written * word_bytes);
        st.tag = tbl_tag[r];
        st.error = dma_pkg::dma_err_t'(tbl_err[r]);
        exp_sts.push_back(st);
        word = word + data_w'(tbl_words[r]);
    endtask

    task automatic check_aw();
        axi_pkg::axi_aw_t want;
        checks++;
        if (exp_aw.size() == 0) begin
            errors++;
            $display("[ERROR] %0t: unexpected AW addr %h len %0d", $time, aw.addr, aw.len);
        end else begin
            want = exp_aw.pop_front();
            if (aw !== want) begin
                errors++;
                $display("[ERROR] %0t: AW addr %h len %0d, expected addr %h len %0d",
                         $time, aw.addr, aw.len, want.addr, want.len);
            end
        end
    endtask

    task automatic check_w();
        axi_pkg::axi_w_t want;
        checks++;
        if (exp_w.size() == 0) begin
            errors++;
            $display("[ERROR] %0t: unexpected W data %h strb %h", $time, w.data, w.strb);
        end else begin
            want = exp_w.pop_front();
            if (w !== want) begin
                errors++;
                $display("[ERROR] %0t: W data %h strb %h last %b, expected %h %h %b",
                         $time, w.data, w.strb, w.last, want.data, want.strb, want.last);
            end
        end
    endtask

    task automatic check_sts();
        dma_pkg::dma_sts_t want;
        checks++;
        sts_seen++;
        if (exp_sts.size() == 0) begin
            errors++;
            $display("[ERROR] %0t: unexpected status tag %h", $time, sts.tag);
        end else begin
            want = exp_sts.pop_front();
            if (sts !== want) begin
                errors++;
                $display("[ERROR] %0t: status len %0d tag %h error %0d, expected %0d %h %0d",
                         $time, sts.len, sts.tag, sts.error, want.len, want.tag, want.error);
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst && !built) begin
            next_word = '0;
            for (int r = 0; r < ROWS; r++) begin
                expect_row(r, next_word);
            end
            built = 1'b1;
        end
        if (!rst) begin
            // desc_ready follows enable one cycle later
            if (desc_ready && !enable_q) begin
                errors++;
                $display("[ERROR] %0t: desc_ready high while enable low", $time);
            end
            if (aw_valid && aw_ready) begin
                check_aw();
            end
            if (w_valid && w_ready) begin
                check_w();
            end
            if (sts_valid) begin
                check_sts();
            end
        end
        enable_q = enable;
        pending = exp_aw.size() + exp_w.size() + exp_sts.size();
    end

endmodule

/* dv/tb_dma_wr.sv */
// AXI4 write DMA testbench
`include "dma_config.svh"

module tb_dma_wr;

    localparam int n_rows = 9;
    // up to 200 cycles per row plus reset and the enable-low phase
    localparam int max_cycles = n_rows * 200 + 50;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   enable;
    dma_pkg::dma_desc_t     desc;
    logic                   desc_valid;
    logic                   desc_ready;
    logic [`DMA_DATA_W-1:0] s_data;
    logic                   s_last;
    logic                   s_valid;
    logic                   s_ready;
    axi_pkg::axi_aw_t       aw;
    logic                   aw_valid;
    logic                   aw_ready = 1'b0;
    axi_pkg::axi_w_t        w;
    logic                   w_valid;
    logic                   w_ready = 1'b0;
    axi_pkg::axi_resp_t     b_resp = axi_pkg::resp_okay;
    logic                   b_valid = 1'b0;
    logic                   b_ready;
    dma_pkg::dma_sts_t      sts;
    logic                   sts_valid;

    logic [`DMA_ADDR_W-1:0] tbl_addr [n_rows];
    logic [`DMA_LEN_W-1:0]  tbl_len [n_rows];
    logic [`DMA_TAG_W-1:0]  tbl_tag [n_rows];
    int                     tbl_words [n_rows];
    int                     tbl_tlast [n_rows];
    logic [15:0]            tbl_bresp [n_rows];
    logic [3:0]             tbl_err [n_rows];

    int                     seed = 32'h5ffd;
    int                     cycles = 0;
    logic [`DMA_DATA_W-1:0] data_count;
    logic [1:0]             resp_q [$];
    int                     wlast_pending = 0;
    int                     aw_seen [n_rows];
    logic                   b_done;
    int                     errors;
    int                     checks;
    int                     sts_seen;
    int                     pending;

    dma_wr_top i_dma_wr_top (.*);

    dma_wr_checker #(.ROWS(n_rows)) i_dma_wr_checker (.*);

    always #10 clk = ~clk;

    task automatic set_row(input int r, input logic [31:0] addr, input int len,
                           input logic [7:0] tag, input int words, input int tlast,
                           input logic [15:0] bresp, input logic [3:0] err);
        tbl_addr[r] = addr;
        tbl_len[r] = `DMA_LEN_W'(len);
        tbl_tag[r] = tag;
        tbl_words[r] = words;
        tbl_tlast[r] = tlast;
        tbl_bresp[r] = bresp;
        tbl_err[r] = err;
    endtask

    task automatic load_desc(input int r);
        desc.addr = tbl_addr[r];
        desc.len = tbl_len[r];
        desc.tag = tbl_tag[r];
        desc_valid = 1'b1;
    endtask

    task automatic send_desc(input int r);
        load_desc(r);
        @(posedge clk);
        while (!desc_ready) begin
            @(posedge clk);
        end
        #2;
        desc_valid = 1'b0;
    endtask

    // stream data is a running word counter from zero
    task automatic send_frame(input int r);
        for (int k = 0; k < tbl_words[r]; k++) begin
            s_data = data_count;
            s_last = k == tbl_tlast[r];
            s_valid = 1'b1;
            @(posedge clk);
            while (!s_ready) begin
                @(posedge clk);
            end
            #2;
            data_count = data_count + 1'b1;
        end
        s_valid = 1'b0;
        s_last = 1'b0;
    endtask

    // the row is found from the AW address and the burst index from the AWs seen so far
    task automatic queue_resp(input logic [`DMA_ADDR_W-1:0] addr);
        logic [1:0] resp;
        resp = 2'b00;
        for (int r = 0; r < n_rows; r++) begin
            if (addr >= tbl_addr[r] && addr < tbl_addr[r] + `DMA_ADDR_W'(tbl_len[r])) begin
                resp = tbl_bresp[r][2*aw_seen[r] +: 2];
                aw_seen[r]++;
            end
        end
        resp_q.push_back(resp);
    endtask

    // AXI slave model with random AW and W ready and one B per burst after its last W beat
    always @(posedge clk) begin
        b_done = b_valid && b_ready;
        if (!rst) begin
            if (aw_valid && aw_ready) begin
                queue_resp(aw.addr);
            end
            if (w_valid && w_ready && w.last) begin
                wlast_pending++;
            end
        end
        #2;
        aw_ready = ($random(seed) & 3) != 0;
        // W is ready about half the time so the beat FIFO fills past half
        w_ready = ($random(seed) & 1) != 0;
        if (b_done) begin
            b_valid = 1'b0;
        end
        if (!b_valid && wlast_pending > 0 && resp_q.size() > 0) begin
            b_resp = axi_pkg::axi_resp_t'(resp_q.pop_front());
            b_valid = 1'b1;
            wlast_pending--;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("timeout after %0d cycles, %0d of %0d statuses seen",
                     cycles, sts_seen, n_rows);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        enable = 1'b0;
        desc = '0;
        desc_valid = 1'b0;
        s_data = '0;
        s_last = 1'b0;
        s_valid = 1'b0;
        data_count = '0;
        // bresp holds two bits per burst with burst 0 in the low bits
        //      row  addr           bytes  tag    words tlast bresp     error
        set_row(0, 32'h0000_1000,  64, 8'h10, 16, 15, 16'h0000, 4'd0);
        set_row(1, 32'h0000_2000, 200, 8'h11, 50, 49, 16'h0000, 4'd0);
        set_row(2, 32'h0000_3fe0,  96, 8'h12, 24, 23, 16'h0000, 4'd0);
        set_row(3, 32'h0000_5000, 128, 8'h13, 20, 19, 16'h0000, 4'd0);
        set_row(4, 32'h0000_6000,  40, 8'h14, 14, 13, 16'h0000, 4'd0);
        set_row(5, 32'h0000_7000, 128, 8'h15, 32, 31, 16'h0002, 4'd6);
        set_row(6, 32'h0000_8000,  32, 8'h16,  8,  7, 16'h0000, 4'd0);
        set_row(7, 32'h0000_9000,  96, 8'h17, 24, 23, 16'h000c, 4'd7);
        set_row(8, 32'h0000_b000, 128, 8'h18, 16, 15, 16'h0000, 4'd0);
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        // a descriptor waits while enable is low
        load_desc(0);
        repeat (10) @(posedge clk);
        #2;
        enable = 1'b1;
        fork
            for (int r = 0; r < n_rows; r++) begin
                send_desc(r);
            end
            for (int r = 0; r < n_rows; r++) begin
                send_frame(r);
            end
        join
        wait (sts_seen == n_rows);
        repeat (20) @(posedge clk);
        if (pending != 0) begin
            $display("%0d expected AW, W or status transfers never appeared", pending);
        end
        $display("checks %0d, errors %0d, missing %0d", checks, errors, pending);
        if (errors == 0 && pending == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+common
common/axi_pkg.sv
common/dma_pkg.sv
source/wr_beat_fifo.sv
dma_wr/dma_wr_ctrl.sv
dma_wr/dma_wr_status.sv
source/dma_wr_top.sv
dv/dma_wr_checker.sv
dv/tb_dma_wr.sv

/* source/dma_wr_top.sv */
// AXI4 write DMA top level
`include "dma_config.svh"

module dma_wr_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   enable,
    input  dma_pkg::dma_desc_t     desc,
    input  logic                   desc_valid,
    output logic                   desc_ready,
    input  logic [`DMA_DATA_W-1:0] s_data,
    input  logic                   s_last,
    input  logic                   s_valid,
    output logic                   s_ready,
    output axi_pkg::axi_aw_t       aw,
    output logic                   aw_valid,
    input  logic                   aw_ready,
    output axi_pkg::axi_w_t        w,
    output logic                   w_valid,
    input  logic                   w_ready,
    input  axi_pkg::axi_resp_t     b_resp,
    input  logic                   b_valid,
    output logic                   b_ready,
    output dma_pkg::dma_sts_t      sts,
    output logic                   sts_valid
);

    axi_pkg::axi_w_t         beat;
    logic                    beat_valid;
    logic                    beat_room;
    dma_pkg::dma_burst_rec_t rec;
    logic                    rec_push;
    logic                    burst_issue;
    logic                    slot_free;

    dma_wr_ctrl i_dma_wr_ctrl (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .desc        (desc),
        .desc_valid  (desc_valid),
        .desc_ready  (desc_ready),
        .s_data      (s_data),
        .s_last      (s_last),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .aw          (aw),
        .aw_valid    (aw_valid),
        .aw_ready    (aw_ready),
        .beat        (beat),
        .beat_valid  (beat_valid),
        .beat_room   (beat_room),
        .rec         (rec),
        .rec_push    (rec_push),
        .burst_issue (burst_issue),
        .slot_free   (slot_free)
    );

    dma_wr_status i_dma_wr_status (
        .clk         (clk),
        .rst         (rst),
        .rec         (rec),
        .rec_push    (rec_push),
        .burst_issue (burst_issue),
        .b_resp      (b_resp),
        .b_valid     (b_valid),
        .b_ready     (b_ready),
        .sts         (sts),
        .sts_valid   (sts_valid),
        .slot_free   (slot_free)
    );

    wr_beat_fifo #(
        .DEPTH_AW (`DMA_BEAT_FIFO_AW)
    ) i_wr_beat_fifo (
        .clk      (clk),
        .rst      (rst),
        .in_beat  (beat),
        .in_valid (beat_valid),
        .room     (beat_room),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready)
    );

endmodule

/* source/wr_beat_fifo.sv */
// W beat output FIFO
`include "dma_config.svh"

module wr_beat_fifo #(
    parameter int DEPTH_AW = `DMA_BEAT_FIFO_AW
) (
    input  logic            clk,
    input  logic            rst,
    input  axi_pkg::axi_w_t in_beat,
    input  logic            in_valid,
    output logic            room,
    output axi_pkg::axi_w_t w,
    output logic            w_valid,
    input  logic            w_ready
);

    axi_pkg::axi_w_t   mem [2**DEPTH_AW];
    logic [DEPTH_AW:0] wr_ptr;
    logic [DEPTH_AW:0] rd_ptr;
    logic [DEPTH_AW:0] fill;
    logic              full;
    logic              empty;
    logic              half_full;
    logic              push;
    logic              pop;

    assign fill = wr_ptr - rd_ptr;
    // fill tops out at 2**DEPTH_AW, so the msb alone means full
    assign full = fill[DEPTH_AW];
    assign empty = fill == '0;
    assign push = in_valid && !full;
    assign pop = !empty && (!w_valid || w_ready);
    assign room = !half_full;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[DEPTH_AW-1:0]] <= in_beat;
        end
        if (pop) begin
            w <= mem[rd_ptr[DEPTH_AW-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            w_valid <= 1'b0;
            half_full <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
                w_valid <= 1'b1;
            end else if (w_ready) begin
                w_valid <= 1'b0;
            end
            // upper half is headroom for beats already in flight
            half_full <= fill >= (DEPTH_AW + 1)'(2**(DEPTH_AW - 1));
        end
    end

    no_overflow: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> !full);

endmodule
